// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int way_num    = 2;
    localparam int set_num    = 64;
    localparam int line_words = 4;
    localparam int sb_depth   = 4;
    localparam int sb_ptr_w   = $clog2(sb_depth);

    typedef logic [31:0]         addr_t;
    typedef logic [31:0]         word_t;
    typedef logic [3:0]          strb_t;
    typedef logic [21:0]         tag_t;
    typedef logic [5:0]          index_t;
    typedef logic [1:0]          woff_t;
    typedef logic [way_num-1:0]  way_t;
    typedef logic [sb_ptr_w-1:0] sb_ptr_t;
    typedef logic [sb_ptr_w:0]   sb_cnt_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // tag RAM byte lanes are all written together
    localparam int tag_bytes = ($bits(tag_entry_t) + 7) / 8;

    typedef struct packed {
        addr_t      addr;
        word_t      wdata;
        // nonzero strobe marks a store
        strb_t      strb;
        logic [1:0] size;
        logic       is_signed;
    } lsu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;
        logic  is_store;
    } lsu_resp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        way_t  hit_way;
    } sb_entry_t;

    typedef struct packed {
        index_t     index;
        woff_t      woff;
        way_t       way;
        logic       tag_we;
        tag_entry_t tag;
        strb_t      strb;
        word_t      data;
    } arr_wr_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
        strb_t sel;
    } wb_m2s_t;

    typedef enum logic [1:0] {
        st_idle,
        st_refill,
        st_drain
    } ctrl_state_t;

endpackage

// ==== source/dpsram.sv ====
`timescale 1ns/100ps

module dpsram #(
    parameter int width = 32,
    parameter int depth = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [$clog2(depth)-1:0]   addr0_i,
    output logic [width-1:0]           rdata0_o,
    input  logic [$clog2(depth)-1:0]   addr1_i,
    input  logic [(width+7)/8-1:0]     we1_i,
    input  logic [width-1:0]           wdata1_i
);

    logic [width-1:0] mem [depth];
    logic [width-1:0] rd_next;

    // same-address write shows through on the read port
    always_comb begin
        rd_next = mem[addr0_i];
        if (addr1_i == addr0_i) begin
            for (int b = 0; b < width; b++) begin
                if (we1_i[b/8]) begin
                    rd_next[b] = wdata1_i[b];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata0_o <= '0;
        end else begin
            rdata0_o <= rd_next;
        end
    end

    // byte-masked write port
    always_ff @(posedge clk) begin
        for (int b = 0; b < width; b++) begin
            if (we1_i[b/8]) begin
                mem[addr1_i][b] <= wdata1_i[b];
            end
        end
    end

endmodule

// ==== source/store_buffer.sv ====
`timescale 1ns/100ps

module store_buffer (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  dcache_pkg::sb_entry_t                            push_i,
    output logic                                             full_o,
    output dcache_pkg::sb_entry_t [dcache_pkg::sb_depth-1:0] table_o,
    output dcache_pkg::sb_entry_t                            head_o,
    output logic                                             empty_o,
    input  logic                                             pop_i
);

    dcache_pkg::sb_entry_t            entry_q [dcache_pkg::sb_depth];
    logic [dcache_pkg::sb_depth-1:0]  valid_q;
    dcache_pkg::sb_ptr_t              head_q;
    dcache_pkg::sb_ptr_t              tail_q;
    dcache_pkg::sb_cnt_t              count_q;
    dcache_pkg::sb_ptr_t              slot;

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i.valid) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (pop_i) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + dcache_pkg::sb_cnt_t'(push_i.valid)
                               - dcache_pkg::sb_cnt_t'(pop_i);
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (push_i.valid) begin
            entry_q[tail_q] <= push_i;
        end
    end

    // oldest entry first so that a later match overrides an earlier one
    always_comb begin
        slot = head_q;
        for (int i = 0; i < dcache_pkg::sb_depth; i++) begin
            table_o[i]       = entry_q[slot];
            table_o[i].valid = valid_q[slot];
            slot             = slot + 1'b1;
        end
    end

    assign head_o  = table_o[0];
    assign empty_o = (count_q == '0);

    // also full when the push in flight takes the last free slot
    assign full_o = (count_q == dcache_pkg::sb_cnt_t'(dcache_pkg::sb_depth))
                 || (count_q == dcache_pkg::sb_cnt_t'(dcache_pkg::sb_depth - 1)
                     && push_i.valid);

endmodule

// ==== source/refill_counter.sv ====
`timescale 1ns/100ps

module refill_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear_i,
    input  logic              step_i,
    output dcache_pkg::woff_t woff_o,
    output logic              last_o
);

    // word offset of the next refill read
    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            woff_o <= '0;
        end else if (step_i) begin
            woff_o <= woff_o + 1'b1;
        end
    end

    assign last_o = (woff_o == dcache_pkg::woff_t'(dcache_pkg::line_words - 1));

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  miss_req_i,
    input  dcache_pkg::addr_t     miss_addr_i,
    input  dcache_pkg::sb_entry_t sb_head_i,
    input  logic                  sb_empty_i,
    output logic                  sb_pop_o,
    input  logic                  commit_i,
    input  dcache_pkg::woff_t     cnt_woff_i,
    input  logic                  cnt_last_i,
    output logic                  cnt_clear_o,
    output logic                  cnt_step_o,
    output dcache_pkg::arr_wr_t   arr_wr_o,
    output logic                  ctrl_busy_o,
    output dcache_pkg::wb_m2s_t   wb_o,
    input  logic                  wb_ack_i,
    input  dcache_pkg::word_t     wb_dat_i
);

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;
    dcache_pkg::sb_cnt_t     pend_q;
    dcache_pkg::index_t      sweep_idx_q;
    logic                    sweep_q;
    logic                    victim_q;
    logic                    drain_go;

    assign drain_go = (pend_q != '0 || commit_i) && !sb_empty_i;

    always_comb begin
        state_d    = state_q;
        wb_o       = '0;
        arr_wr_o   = '0;
        sb_pop_o   = 1'b0;
        cnt_step_o = 1'b0;
        case (state_q)
            dcache_pkg::st_idle: begin
                if (sweep_q) begin
                    // clear both tag ways of one set per cycle
                    arr_wr_o.index  = sweep_idx_q;
                    arr_wr_o.way    = '1;
                    arr_wr_o.tag_we = 1'b1;
                end else if (miss_req_i) begin
                    state_d = dcache_pkg::st_refill;
                end else if (drain_go) begin
                    state_d = dcache_pkg::st_drain;
                end
            end
            dcache_pkg::st_refill: begin
                wb_o.cyc = 1'b1;
                wb_o.stb = 1'b1;
                wb_o.adr = {miss_addr_i[31:4], cnt_woff_i, 2'b00};
                wb_o.sel = '1;
                if (wb_ack_i) begin
                    cnt_step_o     = 1'b1;
                    arr_wr_o.index = miss_addr_i[9:4];
                    arr_wr_o.woff  = cnt_woff_i;
                    arr_wr_o.way   = victim_q ? 2'b10 : 2'b01;
                    arr_wr_o.strb  = '1;
                    arr_wr_o.data  = wb_dat_i;
                    if (cnt_last_i) begin
                        arr_wr_o.tag_we    = 1'b1;
                        arr_wr_o.tag.valid = 1'b1;
                        arr_wr_o.tag.tag   = miss_addr_i[31:10];
                        state_d            = dcache_pkg::st_idle;
                    end
                end
            end
            dcache_pkg::st_drain: begin
                wb_o.cyc = 1'b1;
                wb_o.stb = 1'b1;
                wb_o.we  = 1'b1;
                wb_o.adr = {sb_head_i.addr[31:2], 2'b00};
                wb_o.dat = sb_head_i.wdata;
                wb_o.sel = sb_head_i.strb;
                if (wb_ack_i) begin
                    // zero hit_way leaves the arrays untouched
                    arr_wr_o.index = sb_head_i.addr[9:4];
                    arr_wr_o.woff  = sb_head_i.addr[3:2];
                    arr_wr_o.way   = sb_head_i.hit_way;
                    arr_wr_o.strb  = sb_head_i.strb;
                    arr_wr_o.data  = sb_head_i.wdata;
                    sb_pop_o       = 1'b1;
                    state_d        = dcache_pkg::st_idle;
                end
            end
            default: state_d = dcache_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= dcache_pkg::st_idle;
            pend_q      <= '0;
            sweep_q     <= 1'b1;
            sweep_idx_q <= '0;
            victim_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_q + dcache_pkg::sb_cnt_t'(commit_i)
                              - dcache_pkg::sb_cnt_t'(sb_pop_o);
            if (sweep_q) begin
                sweep_idx_q <= sweep_idx_q + 1'b1;
                if (sweep_idx_q == dcache_pkg::index_t'(dcache_pkg::set_num - 1)) begin
                    sweep_q <= 1'b0;
                end
            end
            if (state_q == dcache_pkg::st_refill && wb_ack_i && cnt_last_i) begin
                victim_q <= ~victim_q;
            end
        end
    end

    assign cnt_clear_o = (state_q == dcache_pkg::st_idle);
    assign ctrl_busy_o = (state_q != dcache_pkg::st_idle) || sweep_q;

endmodule

// ==== source/dcache.sv ====
`timescale 1ns/100ps

module dcache (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             req_valid_i,
    input  dcache_pkg::lsu_req_t                             req_i,
    output logic                                             req_ready_o,
    output logic                                             resp_valid_o,
    output dcache_pkg::lsu_resp_t                            resp_o,
    input  dcache_pkg::sb_entry_t [dcache_pkg::sb_depth-1:0] sb_table_i,
    input  logic                                             sb_full_i,
    output dcache_pkg::sb_entry_t                            sb_push_o,
    input  dcache_pkg::arr_wr_t                              arr_wr_i,
    input  logic                                             ctrl_busy_i,
    output logic                                             miss_req_o,
    output dcache_pkg::addr_t                                miss_addr_o
);

    dcache_pkg::lsu_req_t                            m1_req;
    logic                                            m1_valid;
    logic                                            m1_replay;
    logic                                            m1_miss;
    logic                                            m1_store;
    dcache_pkg::addr_t                               rd_addr;
    dcache_pkg::tag_entry_t [dcache_pkg::way_num-1:0] tag_q;
    dcache_pkg::word_t [dcache_pkg::way_num-1:0]     data_q;
    dcache_pkg::way_t                                tag_hit;
    dcache_pkg::word_t                               ram_word;
    dcache_pkg::word_t                               sb_word;
    dcache_pkg::strb_t                               sb_hit;
    dcache_pkg::strb_t                               rmask;
    dcache_pkg::word_t                               merged;
    dcache_pkg::word_t                               shifted;
    dcache_pkg::word_t                               ld_data;
    logic                                            covered;

    // a held miss keeps re-reading its own line
    assign rd_addr = m1_miss ? m1_req.addr : req_i.addr;

    for (genvar w = 0; w < dcache_pkg::way_num; w++) begin : g_way
        dpsram #(
            .width($bits(dcache_pkg::tag_entry_t)),
            .depth(dcache_pkg::set_num)
        ) i_tag_ram (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr0_i  (rd_addr[9:4]),
            .rdata0_o (tag_q[w]),
            .addr1_i  (arr_wr_i.index),
            .we1_i    ({dcache_pkg::tag_bytes{arr_wr_i.tag_we & arr_wr_i.way[w]}}),
            .wdata1_i (arr_wr_i.tag)
        );

        dpsram #(
            .width($bits(dcache_pkg::word_t)),
            .depth(dcache_pkg::set_num * dcache_pkg::line_words)
        ) i_data_ram (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr0_i  (rd_addr[9:2]),
            .rdata0_o (data_q[w]),
            .addr1_i  ({arr_wr_i.index, arr_wr_i.woff}),
            .we1_i    (arr_wr_i.strb & {4{arr_wr_i.way[w]}}),
            .wdata1_i (arr_wr_i.data)
        );
    end

    // tag compare
    always_comb begin
        tag_hit  = '0;
        ram_word = '0;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (tag_q[w].valid && tag_q[w].tag == m1_req.addr[31:10]) begin
                tag_hit[w] = 1'b1;
                ram_word   = data_q[w];
            end
        end
    end

    // younger store buffer entries win per byte
    always_comb begin
        sb_hit  = '0;
        sb_word = '0;
        for (int i = 0; i < dcache_pkg::sb_depth; i++) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_table_i[i].valid && sb_table_i[i].strb[b]
                    && sb_table_i[i].addr[31:2] == m1_req.addr[31:2]) begin
                    sb_hit[b]         = 1'b1;
                    sb_word[8*b +: 8] = sb_table_i[i].wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        case (m1_req.size)
            2'd0:    rmask = 4'b0001 << m1_req.addr[1:0];
            2'd1:    rmask = m1_req.addr[1] ? 4'b1100 : 4'b0011;
            default: rmask = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = sb_hit[b] ? sb_word[8*b +: 8] : ram_word[8*b +: 8];
        end
    end

    assign covered  = ((rmask & (sb_hit | {4{|tag_hit}})) == rmask);
    assign m1_store = |m1_req.strb;
    assign m1_miss  = m1_valid && !m1_store && !covered;

    // align and extend the loaded value
    assign shifted = merged >> {m1_req.addr[1:0], 3'b000};
    always_comb begin
        case (m1_req.size)
            2'd0:    ld_data = {{24{m1_req.is_signed & shifted[7]}}, shifted[7:0]};
            2'd1:    ld_data = {{16{m1_req.is_signed & shifted[15]}}, shifted[15:0]};
            default: ld_data = merged;
        endcase
    end

    assign req_ready_o = !ctrl_busy_i && !m1_miss && !(sb_full_i && |req_i.strb);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid  <= 1'b0;
            m1_replay <= 1'b0;
        end else if (m1_miss) begin
            m1_replay <= 1'b1;
        end else begin
            m1_valid  <= req_valid_i && req_ready_o;
            m1_replay <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!m1_miss) begin
            m1_req <= req_i;
        end
    end

    assign resp_valid_o    = m1_valid && !m1_miss;
    assign resp_o.rdata    = ld_data;
    assign resp_o.hit      = m1_store ? |tag_hit : covered && !m1_replay;
    assign resp_o.is_store = m1_store;

    assign sb_push_o.valid   = m1_valid && m1_store;
    assign sb_push_o.addr    = m1_req.addr;
    assign sb_push_o.wdata   = m1_req.wdata;
    assign sb_push_o.strb    = m1_req.strb;
    assign sb_push_o.hit_way = tag_hit;

    assign miss_req_o  = m1_miss;
    assign miss_addr_o = m1_req.addr;

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    input  dcache_pkg::lsu_req_t  req_i,
    output logic                  req_ready_o,
    output logic                  resp_valid_o,
    output dcache_pkg::lsu_resp_t resp_o,
    input  logic                  commit_i,
    output dcache_pkg::wb_m2s_t   wb_o,
    input  logic                  wb_ack_i,
    input  dcache_pkg::word_t     wb_dat_i
);

    dcache_pkg::sb_entry_t [dcache_pkg::sb_depth-1:0] sb_table;
    dcache_pkg::sb_entry_t                            sb_push;
    dcache_pkg::sb_entry_t                            sb_head;
    logic                                             sb_full;
    logic                                             sb_empty;
    logic                                             sb_pop;
    dcache_pkg::arr_wr_t                              arr_wr;
    logic                                             ctrl_busy;
    logic                                             miss_req;
    dcache_pkg::addr_t                                miss_addr;
    logic                                             cnt_clear;
    logic                                             cnt_step;
    dcache_pkg::woff_t                                cnt_woff;
    logic                                             cnt_last;

    dcache i_dcache (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .sb_table_i   (sb_table),
        .sb_full_i    (sb_full),
        .sb_push_o    (sb_push),
        .arr_wr_i     (arr_wr),
        .ctrl_busy_i  (ctrl_busy),
        .miss_req_o   (miss_req),
        .miss_addr_o  (miss_addr)
    );

    store_buffer i_store_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (sb_push),
        .full_o  (sb_full),
        .table_o (sb_table),
        .head_o  (sb_head),
        .empty_o (sb_empty),
        .pop_i   (sb_pop)
    );

    cache_ctrl i_cache_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .miss_req_i  (miss_req),
        .miss_addr_i (miss_addr),
        .sb_head_i   (sb_head),
        .sb_empty_i  (sb_empty),
        .sb_pop_o    (sb_pop),
        .commit_i    (commit_i),
        .cnt_woff_i  (cnt_woff),
        .cnt_last_i  (cnt_last),
        .cnt_clear_o (cnt_clear),
        .cnt_step_o  (cnt_step),
        .arr_wr_o    (arr_wr),
        .ctrl_busy_o (ctrl_busy),
        .wb_o        (wb_o),
        .wb_ack_i    (wb_ack_i),
        .wb_dat_i    (wb_dat_i)
    );

    refill_counter i_refill_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (cnt_clear),
        .step_i  (cnt_step),
        .woff_o  (cnt_woff),
        .last_o  (cnt_last)
    );

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

    localparam int max_tests = 64;
    localparam int cols      = 7;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    dcache_pkg::lsu_req_t  req;
    logic                  req_ready;
    logic                  resp_valid;
    dcache_pkg::lsu_resp_t resp;
    logic                  commit;
    dcache_pkg::wb_m2s_t   wb;
    logic                  wb_ack;
    dcache_pkg::word_t     wb_dat;

    logic [31:0]       tests [max_tests*cols];
    int                n_tests;
    int                writes_done;
    dcache_pkg::word_t mem_q [logic [29:0]];

    dcache_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_o       (resp),
        .commit_i     (commit),
        .wb_o         (wb),
        .wb_ack_i     (wb_ack),
        .wb_dat_i     (wb_dat)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // untouched words hold the inverse of their word address
    function automatic dcache_pkg::word_t mem_read(input logic [29:0] waddr);
        if (mem_q.exists(waddr)) begin
            return mem_q[waddr];
        end
        return ~{2'b00, waddr};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual %h expected %h", name, actual, expected);
            fail_run("a checked value did not match");
        end
    endtask

    // wishbone slave with random wait states
    initial begin : mem_model
        logic [31:0]       lfsr_q;
        int                n_wait;
        dcache_pkg::word_t word;
        lfsr_q      = 32'h7a7ce646;
        writes_done = 0;
        wb_ack      = 1'b0;
        wb_dat      = '0;
        forever begin
            @(negedge clk);
            if (rst_n && wb.cyc && wb.stb) begin
                n_wait = 0;
                repeat (2) begin
                    lfsr_q = lfsr_next(lfsr_q);
                    n_wait = (n_wait << 1) | int'(lfsr_q[0]);
                end
                repeat (n_wait) @(negedge clk);
                @(posedge clk);
                #10;
                word = mem_read(wb.adr[31:2]);
                if (wb.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb.sel[b]) begin
                            word[8*b +: 8] = wb.dat[8*b +: 8];
                        end
                    end
                    mem_q[wb.adr[31:2]] = word;
                    writes_done++;
                end
                wb_dat = word;
                wb_ack = 1'b1;
                @(posedge clk);
                #10;
                wb_ack = 1'b0;
            end
        end
    end

    task automatic pulse_commit();
        @(posedge clk);
        #10;
        commit = 1'b1;
        @(posedge clk);
        #10;
        commit = 1'b0;
    endtask

    // the full buffer holds the store until a commit
    task automatic expect_store_held();
        repeat (8) begin
            @(negedge clk);
            check_value("req_ready_o", req_ready, 32'd0);
        end
        pulse_commit();
    endtask

    task automatic issue_request(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [31:0] sz, input logic [31:0] flag,
                                 input logic [31:0] exp_rdata, input logic [31:0] exp_hit,
                                 input logic is_store);
        int lat;
        @(posedge clk);
        #10;
        req.addr      = addr;
        req.wdata     = is_store ? data : '0;
        req.strb      = is_store ? sz[3:0] : 4'h0;
        req.size      = is_store ? 2'd2 : sz[1:0];
        req.is_signed = !is_store && flag[0];
        req_valid     = 1'b1;
        if (is_store && flag[0]) begin
            expect_store_held();
        end
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        lat = 1;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
            lat++;
        end
        check_value("resp_o.is_store", resp.is_store, is_store);
        if (!is_store) begin
            check_value("resp_o.rdata", resp.rdata, exp_rdata);
            check_value("resp_o.hit", resp.hit, exp_hit);
        end
        if (is_store || exp_hit[0]) begin
            check_value("response latency", lat, 32'd1);
        end
    endtask

    task automatic commit_and_compare(input logic [31:0] addr, input logic [31:0] expected);
        int writes_before;
        writes_before = writes_done;
        pulse_commit();
        while (writes_done == writes_before) begin
            @(negedge clk);
        end
        check_value($sformatf("memory word %h", addr), mem_read(addr[31:2]), expected);
    endtask

    initial begin : watchdog
        wait (n_tests > 0);
        repeat (n_tests * 200) @(posedge clk);
        fail_run("timeout, the tests did not finish in time");
    end

    initial begin : stimulus
        logic [31:0] op;
        logic [31:0] f [cols];
        int          cnt;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        commit    = 1'b0;
        n_tests   = 0;
        $readmemh("verif/dcache_tests.txt", tests);
        cnt = 0;
        while (cnt < max_tests && !$isunknown(tests[cnt*cols])) begin
            cnt++;
        end
        if (cnt == 0) begin
            fail_run("no tests could be read from the test file");
        end
        n_tests = cnt;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            for (int c = 0; c < cols; c++) begin
                f[c] = tests[t*cols + c];
            end
            op = f[0];
            case (op)
                0: repeat (f[2]) @(posedge clk);
                1: issue_request(f[1], f[2], f[3], f[4], f[5], f[6], 1'b0);
                2: issue_request(f[1], f[2], f[3], f[4], f[5], f[6], 1'b1);
                3: commit_and_compare(f[1], f[5]);
                default: fail_run("the test file holds an unknown opcode");
            endcase
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verif/dcache_tests.txt ====
// op addr data strb_or_size signed_or_held exp_rdata exp_hit
// op 0 idle (data is cycles) 1 load 2 store 3 commit (exp_rdata is the memory word)
0 00000000 00000004 0 0 00000000 0
1 00001040 00000000 2 0 fffffbef 0
1 00001045 00000000 0 1 fffffffb 1
1 00001045 00000000 0 0 000000fb 1
1 00001044 00000000 1 1 fffffbee 1
1 00001044 00000000 1 0 0000fbee 1
1 00002080 00000000 1 1 fffff7df 0
2 00001048 11223344 3 0 00000000 0
2 00001048 aabbccdd 6 0 00000000 0
1 00001048 00000000 2 0 ffbbcc44 1
3 00001048 00000000 0 0 ffff3344 0
3 00001048 00000000 0 0 ffbbcc44 0
1 000030c0 00000000 2 0 fffff3cf 0
1 00001048 00000000 2 0 ffbbcc44 1
2 00005140 000000a1 1 0 00000000 0
2 00005144 0000b200 2 0 00000000 0
2 00005148 00c30000 4 0 00000000 0
2 0000514c d4000000 8 0 00000000 0
2 00001040 55667788 f 1 00000000 0
3 00005144 00000000 0 0 ffffb2ae 0
3 00005148 00000000 0 0 ffc3ebad 0
3 0000514c 00000000 0 0 d4ffebac 0
3 00001040 00000000 0 0 55667788 0
1 00001040 00000000 2 0 55667788 1
1 00005140 00000000 2 0 ffffeba1 0
1 0000514f 00000000 0 1 ffffffd4 1
1 0000514f 00000000 0 0 000000d4 1
1 00005144 00000000 1 0 0000b2ae 1
1 0000514a 00000000 1 1 ffffffc3 1
0 00000000 00000004 0 0 00000000 0

// ==== dcache_sub.f ====
source/dcache_pkg.sv
source/dpsram.sv
source/store_buffer.sv
source/refill_counter.sv
source/cache_ctrl.sv
source/dcache.sv
source/dcache_top.sv
verif/dcache_tb.sv
